//--- list.f
+incdir+.
asic_pkg.sv
cpu_bus_if.sv
dma_page_decode.sv
crtc_acid_regs.sv
pen_ink_palette.sv
dma_channel_regs.sv
cpu_read_return.sv
asic_registers.sv
tb_clock_gen.sv
tb_scoreboard.sv
tb_asic_registers.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_asic_registers -o sim_asic
./obj_dir/sim_asic | tee sim.log
if grep -qx "All tests passed" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- tb_asic_registers.sv
`timescale 1ns/1ps
`default_nettype none

`include "asic_consts.svh"

module tb_asic_registers
    import asic_pkg::*;
();

    localparam logic [31:0] LFSR_SEED = 32'd89561;
    localparam logic [15:0] DMA_ADDR  = {`ASIC_PAGE_ASIC, `ASIC_DMA_BASE};
    localparam logic [15:0] PEN_STAT  = {`ASIC_PORT_GA, `ASIC_PEN_LAST};

    // Test lengths in clock cycles
    localparam int RESET_CYCLES = 6;
    localparam int CRTC_CYCLES  = 2 * 32 + 1;
    localparam int ACID_CYCLES  = 5 + 1 + 11 + 1 + 17 + 1;
    localparam int PEN_OPS      = 48;
    localparam int DMA_WRITES   = 48;
    localparam int MIX_OPS      = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * CRTC_CYCLES + ACID_CYCLES +
                                  PEN_OPS + PEN_OPS / 4 + 1 + DMA_WRITES + 17 + MIX_OPS + 2;
    localparam longint TIMEOUT_NS = longint'(TOTAL_CYCLES) * 40 * 2;

    logic        clk_sys;
    logic        reset;
    logic [15:0] cpu_addr;
    asic_byte_t  cpu_data_in;
    logic        cpu_wr;
    logic        cpu_rd;
    asic_byte_t  cpu_data_out;
    logic        cpu_data_out_en;
    asic_byte_t  crtc_regs [32];
    asic_byte_t  crtc_reg_select;
    logic        acid_unlocked;
    pen_index_t  current_pen;
    ink_t        pen_ink;
    asic_byte_t  dcsr;
    dma_ptr_t    dma_ptr [3];
    asic_byte_t  dma_prescale [3];
    int          sb_errors;
    logic [31:0] lfsr_state;

    tb_clock_gen u_clk (.clk_sys(clk_sys), .reset(reset));

    asic_registers dut (.*);

    tb_scoreboard sb (.*, .error_count(sb_errors));

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw(input int nbits, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[14:0], lfsr_state[0]};
        end
    endtask

    task automatic bus_cycle(input logic wr, input logic rd, input logic [15:0] addr,
                             input asic_byte_t data);
        @(posedge clk_sys);
        #5;
        cpu_wr      = wr;
        cpu_rd      = rd;
        cpu_addr    = addr;
        cpu_data_in = data;
    endtask

    task automatic idle();
        bus_cycle(1'b0, 1'b0, 16'h0000, 8'h00);
    endtask

    task automatic sel_write(input asic_byte_t value);
        bus_cycle(1'b1, 1'b0, `ASIC_PORT_CRTC_SEL, value);
    endtask

    // Select then write every CRTC register once
    task automatic crtc_pass();
        logic [15:0] v;
        for (int n = 0; n < 32; n++) begin
            draw(8, v);
            sel_write(8'(n));
            bus_cycle(1'b1, 1'b0, `ASIC_PORT_CRTC_DATA, v[7:0] | 8'h01);  // Never zero
        end
        idle();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: stimulus still running after %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [15:0] a;
        logic [15:0] d;
        logic [15:0] k;
        cpu_addr    = '0;
        cpu_data_in = '0;
        cpu_wr      = 1'b0;
        cpu_rd      = 1'b0;
        lfsr_state  = LFSR_SEED;
        @(negedge reset);

        sb.begin_test("reset");
        repeat (RESET_CYCLES - 2) idle();
        sb.end_test();

        sb.begin_test("crtc_locked");
        crtc_pass();
        sb.end_test();

        sb.begin_test("acid_unlock");
        for (int i = 0; i < 5; i++) begin
            sel_write(sb.acid_byte(i));
        end
        sel_write(8'h5A);  // Wrong byte at position 5
        for (int i = 5; i < 16; i++) begin
            sel_write(sb.acid_byte(i));
        end
        idle();
        sb.compare("acid_unlocked after broken run", 16'd0, 16'(acid_unlocked));
        for (int i = 0; i < 16; i++) begin
            sel_write(sb.acid_byte(i));
            if (i == 7) begin
                sel_write(sb.acid_byte(i));  // Repeat must be ignored
            end
        end
        idle();
        sb.compare("acid_unlocked after full run", 16'd1, 16'(acid_unlocked));
        sb.end_test();

        sb.begin_test("crtc_unlocked");
        crtc_pass();
        sb.end_test();

        sb.begin_test("pen_ink");
        for (int n = 0; n < PEN_OPS; n++) begin
            draw(5, a);
            draw(8, d);
            bus_cycle(1'b1, 1'b0, {`ASIC_PORT_GA, 8'(a % 17)}, d[7:0]);
            if (n % 4 == 3) begin
                bus_cycle(1'b0, 1'b1, PEN_STAT, 8'h00);
            end
        end
        idle();
        sb.end_test();

        sb.begin_test("dma_page");
        for (int n = 0; n < DMA_WRITES; n++) begin
            draw(4, a);
            draw(8, d);
            bus_cycle(1'b1, 1'b0, DMA_ADDR + a, d[7:0]);
        end
        for (int s = 0; s < 16; s++) begin
            bus_cycle(1'b0, 1'b1, DMA_ADDR + 16'(s), 8'h00);
        end
        idle();
        sb.end_test();

        // Weighted toward the decoded ports and the DMA page
        sb.begin_test("random_mix");
        for (int n = 0; n < MIX_OPS; n++) begin
            draw(3, k);
            draw(16, a);
            draw(8, d);
            case (k[2:0])
                3'd0: sel_write({3'b000, a[4:0]});
                3'd1: bus_cycle(1'b1, 1'b0, `ASIC_PORT_CRTC_DATA, d[7:0]);
                3'd2: bus_cycle(1'b1, 1'b0, {`ASIC_PORT_GA, 8'(a % 17)}, d[7:0]);
                3'd3: bus_cycle(1'b0, 1'b1, PEN_STAT, 8'h00);
                3'd4: bus_cycle(1'b1, 1'b0, DMA_ADDR + a[3:0], d[7:0]);
                3'd5: bus_cycle(1'b0, 1'b1, DMA_ADDR + a[3:0], 8'h00);
                3'd6: bus_cycle(d[0], !d[0], a, d[7:0]);  // Anywhere in the map
                default: idle();
            endcase
        end
        idle();
        idle();  // Last access compared before the totals
        sb.end_test();

        sb.report_totals();
        if (sb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "asic_consts.svh"

module tb_scoreboard
    import asic_pkg::*;
(
    input  wire             clk_sys,
    input  wire             reset,
    input  wire [15:0]      cpu_addr,
    input  wire asic_byte_t cpu_data_in,
    input  wire             cpu_wr,
    input  wire             cpu_rd,
    input  wire asic_byte_t cpu_data_out,
    input  wire             cpu_data_out_en,
    input  wire asic_byte_t crtc_regs [32],
    input  wire asic_byte_t crtc_reg_select,
    input  wire             acid_unlocked,
    input  wire pen_index_t current_pen,
    input  wire ink_t       pen_ink,
    input  wire asic_byte_t dcsr,
    input  wire dma_ptr_t   dma_ptr [3],
    input  wire asic_byte_t dma_prescale [3],
    output int              error_count
);

    localparam logic [15:0] DMA_ADDR = {`ASIC_PAGE_ASIC, `ASIC_DMA_BASE};

    // Unlock sequence as sent on the CRTC select port
    localparam asic_byte_t ACID_BYTES [`ASIC_ACID_LEN] = '{
        8'hAA, 8'h00, 8'hFF, 8'h77, 8'hB3, 8'h51, 8'hA8, 8'hD4,
        8'h62, 8'h39, 8'h9C, 8'h46, 8'h2B, 8'h15, 8'h8A, 8'hCD
    };

    asic_byte_t m_regs [32];
    asic_byte_t m_sel;
    asic_byte_t m_sel_prev;
    int         m_acid_pos;
    logic       m_unlocked;
    pen_index_t m_pen;
    ink_t       m_ink [16];
    asic_byte_t m_dcsr;
    dma_ptr_t   m_ptr [3];
    asic_byte_t m_pre [3];
    asic_byte_t m_out;
    logic       m_out_en;
    logic       model_valid = 1'b0;  // Set at the first reset edge
    string      test_name = "startup";
    int         checks = 0;
    int         test_checks = 0;
    int         test_errors = 0;
    int         tests_run = 0;

    initial error_count = 0;

    function automatic asic_byte_t acid_byte(input int i);
        return ACID_BYTES[i];
    endfunction

    function automatic asic_byte_t read_value(input logic [15:0] a);
        logic [1:0] ch;
        logic [1:0] slot;
        ch   = a[3:2];
        slot = a[1:0];
        if (a == {`ASIC_PORT_GA, `ASIC_PEN_LAST}) begin
            return {3'b000, m_pen[4] ? m_ink[m_pen[3:0]] : m_pen};  // Pen/ink status
        end
        if (a[15:4] != DMA_ADDR[15:4]) begin
            return `ASIC_IDLE_BYTE;
        end
        if (a[3:0] == `ASIC_DCSR_SLOT) begin
            return m_dcsr;
        end
        if (ch == 2'd3 || slot == 2'd3) begin
            return `ASIC_IDLE_BYTE;
        end
        case (slot)
            2'd0:    return m_ptr[ch][7:0];
            2'd1:    return m_ptr[ch][15:8];
            default: return m_pre[ch];
        endcase
    endfunction

    task automatic apply_write(input logic [15:0] a, input asic_byte_t d);
        if (a == `ASIC_PORT_CRTC_SEL) begin
            if (!m_unlocked && d != m_sel_prev) begin
                if (d == ACID_BYTES[m_acid_pos]) begin
                    m_acid_pos++;
                    m_unlocked = (m_acid_pos == `ASIC_ACID_LEN);
                end else begin
                    m_acid_pos = 0;
                end
            end
            m_sel      = d;
            m_sel_prev = d;
        end
        if (a == `ASIC_PORT_CRTC_DATA && m_sel < 32 && (m_unlocked || m_sel < 16)) begin
            m_regs[m_sel[4:0]] = d;
        end
        if (a[15:8] == `ASIC_PORT_GA && a[7:0] <= `ASIC_PEN_LAST) begin
            if (d[7:6] == 2'b00) begin
                m_pen = d[4:0];
            end else begin
                m_ink[m_pen[3:0]] = d[4:0];
            end
        end
        if (a[15:4] == DMA_ADDR[15:4]) begin
            if (a[3:0] == `ASIC_DCSR_SLOT) begin
                m_dcsr = d;
            end else if (a[3:2] != 2'd3) begin
                case (a[1:0])
                    2'd0: m_ptr[a[3:2]][7:0]  = d;
                    2'd1: m_ptr[a[3:2]][15:8] = d;
                    2'd2: m_pre[a[3:2]]       = d;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic reset_model();
        m_sel      = '0;
        m_sel_prev = '0;
        m_acid_pos = 0;
        m_unlocked = 1'b0;
        m_pen      = '0;
        m_dcsr     = '0;
        m_out      = `ASIC_IDLE_BYTE;
        m_out_en   = 1'b0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_ink[i]) m_ink[i] = '0;
        foreach (m_ptr[i]) m_ptr[i] = '0;
        foreach (m_pre[i]) m_pre[i] = '0;
    endtask

    task automatic compare(input string what, input logic [15:0] expected,
                           input logic [15:0] actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("[ERROR] test %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        compare("cpu_data_out", m_out, cpu_data_out);
        compare("cpu_data_out_en", m_out_en, cpu_data_out_en);
        compare("crtc_reg_select", m_sel, crtc_reg_select);
        compare("acid_unlocked", m_unlocked, acid_unlocked);
        compare("current_pen", m_pen, current_pen);
        compare("pen_ink", m_ink[m_pen[3:0]], pen_ink);
        compare("dcsr", m_dcsr, dcsr);
        for (int i = 0; i < 32; i++) begin
            compare($sformatf("crtc_regs[%0d]", i), m_regs[i], crtc_regs[i]);
        end
        for (int i = 0; i < 3; i++) begin
            compare($sformatf("dma_ptr[%0d]", i), m_ptr[i], dma_ptr[i]);
            compare($sformatf("dma_prescale[%0d]", i), m_pre[i], dma_prescale[i]);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-14s %7d checks  %0d errors  %s", test_name, test_checks,
                 test_errors, test_errors == 0 ? "ok" : "FAIL");
    endtask

    task automatic report_totals();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, error_count);
    endtask

    // Model steps on the same edge as the DUT, read data from pre-write state
    always @(posedge clk_sys) begin
        if (reset) begin
            reset_model();
            model_valid = 1'b1;
        end else if (model_valid) begin
            m_out_en = cpu_rd;
            m_out    = cpu_rd ? read_value(cpu_addr) : `ASIC_IDLE_BYTE;
            if (cpu_wr) begin
                apply_write(cpu_addr, cpu_data_in);
            end
        end
    end

    always @(negedge clk_sys) begin
        if (model_valid) begin
            compare_outputs();  // Mid-cycle, outputs settled
        end
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_sys,
    output logic reset
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #5 reset = 1'b0;  // Same offset as the bus inputs
    end

endmodule

`default_nettype wire

//--- asic_registers.sv
`timescale 1ns/1ps
`default_nettype none

module asic_registers
    import asic_pkg::*;
(
    input  wire        clk_sys,
    input  wire        reset,
    input  wire [15:0] cpu_addr,
    input  wire asic_byte_t cpu_data_in,
    input  wire        cpu_wr,
    input  wire        cpu_rd,
    output asic_byte_t cpu_data_out,
    output logic       cpu_data_out_en,
    output asic_byte_t crtc_regs [32],
    output asic_byte_t crtc_reg_select,
    output logic       acid_unlocked,
    output pen_index_t current_pen,
    output ink_t       pen_ink,
    output asic_byte_t dcsr,
    output dma_ptr_t   dma_ptr [3],
    output asic_byte_t dma_prescale [3]
);

    wire        crtc_sel_wr;
    wire        crtc_data_wr;
    wire        pen_wr;
    wire        pen_rd;
    wire asic_byte_t pen_status;

    cpu_bus_if bus ();

    dma_page_decode u_decode (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_wr       (cpu_wr),
        .cpu_rd       (cpu_rd),
        .bus          (bus.source),
        .crtc_sel_wr  (crtc_sel_wr),
        .crtc_data_wr (crtc_data_wr),
        .pen_wr       (pen_wr),
        .pen_rd       (pen_rd),
        .dcsr         (dcsr)
    );

    crtc_acid_regs u_crtc (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .crtc_sel_wr     (crtc_sel_wr),
        .crtc_data_wr    (crtc_data_wr),
        .wdata           (cpu_data_in),
        .crtc_regs       (crtc_regs),
        .crtc_reg_select (crtc_reg_select),
        .acid_unlocked   (acid_unlocked)
    );

    pen_ink_palette u_palette (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .pen_wr      (pen_wr),
        .wdata       (cpu_data_in),
        .current_pen (current_pen),
        .pen_ink     (pen_ink),
        .pen_status  (pen_status)
    );

    // One register set per DMA channel
    for (genvar i = 0; i < $size(dma_ptr); i++) begin : g_dma
        dma_channel_regs #(.CHANNEL(i)) u_chan (
            .clk_sys  (clk_sys),
            .reset    (reset),
            .bus      (bus.sink),
            .ptr      (dma_ptr[i]),
            .prescale (dma_prescale[i])
        );
    end

    cpu_read_return u_read (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .pen_rd          (pen_rd),
        .pen_status      (pen_status),
        .dcsr            (dcsr),
        .dma_ptr         (dma_ptr),
        .dma_prescale    (dma_prescale),
        .bus             (bus.sink),
        .cpu_data_out    (cpu_data_out),
        .cpu_data_out_en (cpu_data_out_en)
    );

endmodule

`default_nettype wire

//--- cpu_read_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "asic_consts.svh"

module cpu_read_return
    import asic_pkg::*;
(
    input  wire        clk_sys,
    input  wire        reset,
    input  wire        pen_rd,
    input  wire asic_byte_t pen_status,
    input  wire asic_byte_t dcsr,
    input  wire dma_ptr_t   dma_ptr [`ASIC_DMA_CHANNELS],
    input  wire asic_byte_t dma_prescale [`ASIC_DMA_CHANNELS],
    cpu_bus_if.sink    bus,
    output asic_byte_t cpu_data_out,
    output logic       cpu_data_out_en
);

    logic [1:0] chan;
    logic [1:0] slot;
    asic_byte_t rd_value;

    assign chan = bus.addr.mem.offset[3:2];
    assign slot = bus.addr.mem.offset[1:0];

    always_comb begin
        rd_value = `ASIC_IDLE_BYTE;  // Unclaimed reads float high
        if (pen_rd) begin
            rd_value = pen_status;
        end else if (bus.dma_rd) begin
            if (bus.addr.mem.offset[3:0] == `ASIC_DCSR_SLOT) begin
                rd_value = dcsr;
            end else if (chan < `ASIC_DMA_CHANNELS) begin
                case (slot)
                    2'd0: rd_value = dma_ptr[chan][7:0];
                    2'd1: rd_value = dma_ptr[chan][15:8];
                    2'd2: rd_value = dma_prescale[chan];
                    default: rd_value = `ASIC_IDLE_BYTE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_data_out    <= `ASIC_IDLE_BYTE;
            cpu_data_out_en <= 1'b0;
        end else begin
            cpu_data_out    <= bus.rd ? rd_value : `ASIC_IDLE_BYTE;
            cpu_data_out_en <= bus.rd;  // Any read drives the bus
        end
    end

    // Block read strobes are qualified copies of rd and never overlap
    a_rd_strobes: assert property (@(posedge clk_sys) disable iff (reset)
        (pen_rd || bus.dma_rd) |-> (bus.rd && !(pen_rd && bus.dma_rd)));

endmodule

`default_nettype wire

//--- dma_channel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_channel_regs
    import asic_pkg::*;
#(
    parameter int CHANNEL = 0
) (
    input  wire        clk_sys,
    input  wire        reset,
    cpu_bus_if.sink    bus,
    output dma_ptr_t   ptr,
    output asic_byte_t prescale
);

    logic claim;

    // Four bytes per channel inside the page
    assign claim = bus.dma_wr && (bus.addr.mem.offset[3:2] == 2'(CHANNEL));

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ptr      <= '0;
            prescale <= '0;
        end else if (claim) begin
            case (bus.addr.mem.offset[1:0])
                2'd0: ptr[7:0]  <= bus.wdata;
                2'd1: ptr[15:8] <= bus.wdata;
                2'd2: prescale  <= bus.wdata;
                default: ;  // Slot 3 unused
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pen_ink_palette.sv
`timescale 1ns/1ps
`default_nettype none

`include "asic_consts.svh"

module pen_ink_palette
    import asic_pkg::*;
(
    input  wire        clk_sys,
    input  wire        reset,
    input  wire        pen_wr,
    input  wire asic_byte_t wdata,
    output pen_index_t current_pen,
    output ink_t       pen_ink,
    output asic_byte_t pen_status
);

    ink_t ink_mem [16];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            current_pen <= '0;
            for (int i = 0; i < 16; i++) begin
                ink_mem[i] <= '0;
            end
        end else if (pen_wr) begin
            if (wdata[7:6] == 2'b00) begin
                current_pen <= wdata[4:0];            // Pen select
            end else begin
                ink_mem[current_pen[3:0]] <= wdata[4:0];  // Ink for selected pen
            end
        end
    end

    assign pen_ink = ink_mem[current_pen[3:0]];

    // Status at 7F10h, ink when pointer bit 4 is set
    assign pen_status = {3'b000, current_pen[4] ? pen_ink : current_pen};

endmodule

`default_nettype wire

//--- crtc_acid_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "asic_consts.svh"

module crtc_acid_regs
    import asic_pkg::*;
(
    input  wire        clk_sys,
    input  wire        reset,
    input  wire        crtc_sel_wr,
    input  wire        crtc_data_wr,
    input  wire asic_byte_t wdata,
    output asic_byte_t crtc_regs [2*`ASIC_CRTC_STD],
    output asic_byte_t crtc_reg_select,
    output logic       acid_unlocked
);

    localparam int POS_W = $clog2(`ASIC_ACID_LEN) + 1;  // One spare bit past the end

    localparam asic_byte_t ACID_SEQ [`ASIC_ACID_LEN] = '{
        8'hAA, 8'h00, 8'hFF, 8'h77, 8'hB3, 8'h51, 8'hA8, 8'hD4,
        8'h62, 8'h39, 8'h9C, 8'h46, 8'h2B, 8'h15, 8'h8A, 8'hCD
    };

    asic_byte_t       sel_prev;
    logic [POS_W-1:0] acid_pos;
    logic             data_open;

    // Extended registers need the unlock
    assign data_open = (crtc_reg_select < 2*`ASIC_CRTC_STD) &&
                       (acid_unlocked || crtc_reg_select < `ASIC_CRTC_STD);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            crtc_reg_select <= '0;
            sel_prev        <= '0;
            acid_pos        <= '0;
            acid_unlocked   <= 1'b0;
            for (int i = 0; i < 2*`ASIC_CRTC_STD; i++) begin
                crtc_regs[i] <= '0;
            end
        end else begin
            if (crtc_sel_wr) begin
                crtc_reg_select <= wdata;
                sel_prev        <= wdata;
                // Repeated select bytes are ignored by the detector
                if (!acid_unlocked && wdata != sel_prev) begin
                    if (wdata == ACID_SEQ[acid_pos[POS_W-2:0]]) begin
                        acid_pos <= acid_pos + 1'b1;
                        if (acid_pos == POS_W'(`ASIC_ACID_LEN - 1)) begin
                            acid_unlocked <= 1'b1;  // Sticky until reset
                        end
                    end else begin
                        acid_pos <= '0;  // Start over
                    end
                end
            end
            if (crtc_data_wr && data_open) begin
                crtc_regs[crtc_reg_select[4:0]] <= wdata;
            end
        end
    end

    a_unlock_sticky: assert property (@(posedge clk_sys)
        $fell(acid_unlocked) |-> $past(reset));

    a_pos_range: assert property (@(posedge clk_sys) disable iff (reset)
        !acid_unlocked |-> acid_pos < `ASIC_ACID_LEN);

endmodule

`default_nettype wire

//--- dma_page_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "asic_consts.svh"

module dma_page_decode
    import asic_pkg::*;
(
    input  wire        clk_sys,
    input  wire        reset,
    input  wire cpu_addr_u  cpu_addr,
    input  wire asic_byte_t cpu_data_in,
    input  wire        cpu_wr,
    input  wire        cpu_rd,
    cpu_bus_if.source  bus,
    output logic       crtc_sel_wr,
    output logic       crtc_data_wr,
    output logic       pen_wr,
    output logic       pen_rd,
    output asic_byte_t dcsr
);

    logic dma_hit;
    logic pen_hit;

    // Register page view
    assign dma_hit = (cpu_addr.mem.page == `ASIC_PAGE_ASIC) &&
                     (cpu_addr.mem.offset >= `ASIC_DMA_BASE) &&
                     (cpu_addr.mem.offset < `ASIC_DMA_BASE + `ASIC_DMA_SPAN);

    // Port view
    assign pen_hit = (cpu_addr.io.port_hi == `ASIC_PORT_GA) &&
                     (cpu_addr.io.port_lo <= `ASIC_PEN_LAST);

    assign crtc_sel_wr  = cpu_wr && (cpu_addr.io == `ASIC_PORT_CRTC_SEL);
    assign crtc_data_wr = cpu_wr && (cpu_addr.io == `ASIC_PORT_CRTC_DATA);
    assign pen_wr       = cpu_wr && pen_hit;
    assign pen_rd       = cpu_rd && pen_hit && (cpu_addr.io.port_lo == `ASIC_PEN_LAST);

    assign bus.wr     = cpu_wr;
    assign bus.rd     = cpu_rd;
    assign bus.addr   = cpu_addr;
    assign bus.wdata  = cpu_data_in;
    assign bus.dma_wr = cpu_wr && dma_hit;
    assign bus.dma_rd = cpu_rd && dma_hit;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dcsr <= '0;
        end else if (bus.dma_wr && cpu_addr.mem.offset[3:0] == `ASIC_DCSR_SLOT) begin
            dcsr <= cpu_data_in;  // 6C0Fh
        end
    end

    // One access per cycle from the CPU side
    a_wr_rd_excl: assert property (@(posedge clk_sys) disable iff (reset)
        !(bus.wr && bus.rd));

endmodule

`default_nettype wire

//--- cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if
    import asic_pkg::*;
();

    logic       wr;      // Raw CPU strobes
    logic       rd;
    cpu_addr_u  addr;
    asic_byte_t wdata;
    logic       dma_wr;  // Strobes inside 6C00h..6C0Fh
    logic       dma_rd;

    modport source (
        output wr, rd, addr, wdata, dma_wr, dma_rd
    );

    modport sink (
        input wr, rd, addr, wdata, dma_wr, dma_rd
    );

endinterface

`default_nettype wire

//--- asic_pkg.sv
`default_nettype none

package asic_pkg;

    typedef logic [7:0] asic_byte_t;

    // One CPU address, seen as an I/O port or as a memory page offset
    typedef union packed {
        struct packed {
            logic [7:0] port_hi;
            logic [7:0] port_lo;
        } io;
        struct packed {
            logic [1:0]  page;    // 16K page
            logic [13:0] offset;
        } mem;
    } cpu_addr_u;

    typedef logic [15:0] dma_ptr_t;  // Low and high byte
    typedef logic [4:0]  pen_index_t;
    typedef logic [4:0]  ink_t;      // Hardware colour number

endpackage

`default_nettype wire

//--- asic_consts.svh
`ifndef ASIC_CONSTS_SVH
`define ASIC_CONSTS_SVH

// I/O port decode
`define ASIC_PORT_GA        8'h7F     // Gate-array high byte
`define ASIC_PORT_CRTC_SEL  16'hBC00
`define ASIC_PORT_CRTC_DATA 16'hBD00
`define ASIC_PEN_LAST       8'h10     // 7F00h..7F10h are pen/ink ports

// Memory-mapped register page, 4000h..7FFFh
`define ASIC_PAGE_ASIC      2'd1
`define ASIC_DMA_BASE       14'h2C00  // 6C00h
`define ASIC_DMA_SPAN       16
`define ASIC_DMA_CHANNELS   3
`define ASIC_DCSR_SLOT      4'd15     // 6C0Fh

// CRTC extension unlock
`define ASIC_ACID_LEN       16
`define ASIC_CRTC_STD       16        // Registers open while locked

// Undriven read data
`define ASIC_IDLE_BYTE      8'hFF

`endif
